// File: verilog/board_io_pkg.sv
`default_nettype none

package board_io_pkg;

    // pins on the board itself
    localparam int n_board_switches = 10;
    localparam int n_board_keys     = 2;

    // widths as seen by the processor side
    localparam int n_switches   = 16;
    localparam int n_buttons    = 8;
    localparam int n_red_leds   = 10;
    localparam int n_green_leds = 8;

    // seven-segment display
    localparam int n_hex_digits    = 6;
    localparam int hex_digit_width = 4;
    localparam int hex_word_width  = n_hex_digits * hex_digit_width;
    // segment pattern plus decimal point
    localparam int hex_port_width  = 8;

    // bus geometry, byte addressed, word registers
    localparam int bus_addr_width  = 8;
    localparam int bus_data_width  = 32;
    localparam int reg_index_lsb   = 2;
    localparam int reg_index_width = 3;

    // register word indexes
    localparam logic [reg_index_width-1:0] reg_switches   = 3'd0;
    localparam logic [reg_index_width-1:0] reg_buttons    = 3'd1;
    localparam logic [reg_index_width-1:0] reg_red_leds   = 3'd2;
    localparam logic [reg_index_width-1:0] reg_green_leds = 3'd3;
    localparam logic [reg_index_width-1:0] reg_hex        = 3'd4;

    // switches and buttons are debounced as one word
    localparam int n_db_inputs          = n_switches + n_buttons;
    // stable cycles needed after the synchronizer
    localparam int debounce_cycles      = 8;
    localparam int debounce_count_width = $clog2(debounce_cycles + 1);

    // active-low segments, segment a in bit 0, g in bit 6
    typedef logic [6:0] seg_t;

    // pattern for "0", everything lit except g
    localparam seg_t seg_zero = 7'b100_0000;

    // decimal point is active low too, so 1 keeps it dark
    localparam logic dp_off = 1'b1;

    // hex register: the bus writes it as one raw value,
    // the display reads it back nibble by nibble
    typedef union packed {
        logic [hex_word_width-1:0]                    raw;
        logic [n_hex_digits-1:0][hex_digit_width-1:0] digit;
    } hex_word_t;

    // reset contents of the writable registers
    localparam logic [n_red_leds-1:0]   red_leds_reset   = '0;
    localparam logic [n_green_leds-1:0] green_leds_reset = '0;
    localparam hex_word_t               hex_reset        = '0;

    // bus_rdata before the first read
    localparam logic [bus_data_width-1:0] rdata_reset = '0;

endpackage

`default_nettype wire

// File: verilog/input_debouncer.sv
`default_nettype none

module input_debouncer (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic [board_io_pkg::n_switches-1:0]  switches_raw,
    input  logic [board_io_pkg::n_buttons-1:0]   buttons_raw,
    output logic [board_io_pkg::n_switches-1:0]  switches_db,
    output logic [board_io_pkg::n_buttons-1:0]   buttons_db
);

    import board_io_pkg::*;

    // buttons in the upper part, switches in the lower part
    logic [n_db_inputs-1:0]          raw_word;
    logic [n_db_inputs-1:0]          sync_q1;
    logic [n_db_inputs-1:0]          sync_q2;
    logic [n_db_inputs-1:0]          candidate;
    logic [n_db_inputs-1:0]          stable_word;
    logic [debounce_count_width-1:0] stable_count;
    logic                            candidate_match;
    logic                            count_full;
    logic                            accept;

    assign raw_word = {buttons_raw, switches_raw};

    // two-flop synchronizer, every bit on its own
    always_ff @(posedge clk) begin
        if (reset) begin
            sync_q1 <= '0;
            sync_q2 <= '0;
        end else begin
            sync_q1 <= raw_word;
            sync_q2 <= sync_q1;
        end
    end

    // any bit moving restarts the whole word
    assign candidate_match = (sync_q2 == candidate);
    assign count_full      = (stable_count == debounce_count_width'(debounce_cycles));

    // counter reaches debounce_cycles on this edge
    assign accept = candidate_match
                 && (stable_count == debounce_count_width'(debounce_cycles - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            candidate    <= '0;
            stable_count <= '0;
        end else if (!candidate_match) begin
            candidate    <= sync_q2;
            stable_count <= '0;
        end else if (!count_full) begin
            // saturates once the word is accepted
            stable_count <= stable_count + 1'b1;
        end
    end

    // outputs only follow a candidate that held long enough
    always_ff @(posedge clk) begin
        if (reset) begin
            stable_word <= '0;
        end else if (accept) begin
            stable_word <= candidate;
        end
    end

    assign {buttons_db, switches_db} = stable_word;

endmodule

`default_nettype wire

// File: verilog/io_register_file.sv
`default_nettype none

module io_register_file (
    input  logic                                     clk,
    input  logic                                     reset,

    // processor side, plain strobes
    input  logic                                     bus_sel,
    input  logic                                     bus_write,
    input  logic [board_io_pkg::bus_addr_width-1:0]  bus_addr,
    input  logic [board_io_pkg::bus_data_width-1:0]  bus_wdata,
    output logic [board_io_pkg::bus_data_width-1:0]  bus_rdata,

    // debounced board inputs
    input  logic [board_io_pkg::n_switches-1:0]      switches_db,
    input  logic [board_io_pkg::n_buttons-1:0]       buttons_db,

    // board outputs
    output logic [board_io_pkg::n_red_leds-1:0]      red_leds,
    output logic [board_io_pkg::n_green_leds-1:0]    green_leds,
    output board_io_pkg::hex_word_t                  hex_value
);

    import board_io_pkg::*;

    logic [reg_index_width-1:0] reg_index;
    logic                       write_strobe;
    logic                       read_strobe;
    logic [bus_data_width-1:0]  read_word;

    // word index from byte address bits 4..2
    // low byte-lane bits and upper bits are ignored
    assign reg_index = bus_addr[reg_index_lsb +: reg_index_width];

    assign write_strobe = bus_sel &&  bus_write;
    assign read_strobe  = bus_sel && !bus_write;

    // writable registers
    // write lands on the same edge as the strobe
    always_ff @(posedge clk) begin
        if (reset) begin
            red_leds   <= red_leds_reset;
            green_leds <= green_leds_reset;
            hex_value  <= hex_reset;
        end else if (write_strobe) begin
            case (reg_index)
                reg_red_leds: begin
                    red_leds <= bus_wdata[n_red_leds-1:0];
                end
                reg_green_leds: begin
                    green_leds <= bus_wdata[n_green_leds-1:0];
                end
                reg_hex: begin
                    hex_value.raw <= bus_wdata[hex_word_width-1:0];
                end
                // switch and button words are read-only,
                // unmapped indexes drop the write
                default: begin
                end
            endcase
        end
    end

    // read mux, narrow registers zero-extended
    always_comb begin
        read_word = '0;
        case (reg_index)
            reg_switches: begin
                read_word[n_switches-1:0] = switches_db;
            end
            reg_buttons: begin
                read_word[n_buttons-1:0] = buttons_db;
            end
            reg_red_leds: begin
                read_word[n_red_leds-1:0] = red_leds;
            end
            reg_green_leds: begin
                read_word[n_green_leds-1:0] = green_leds;
            end
            reg_hex: begin
                read_word[hex_word_width-1:0] = hex_value.raw;
            end
            // indexes 5..7 read zero
            default: begin
                read_word = '0;
            end
        endcase
    end

    // one-cycle read latency
    // data holds until the next selected read,
    // so back-to-back reads each get their own word
    always_ff @(posedge clk) begin
        if (reset) begin
            bus_rdata <= rdata_reset;
        end else if (read_strobe) begin
            bus_rdata <= read_word;
        end
    end

endmodule

`default_nettype wire

// File: verilog/hex_display_driver.sv
`default_nettype none

module hex_display_driver (
    input  logic                                    clk,
    input  logic                                    reset,
    input  board_io_pkg::hex_word_t                 hex_value,
    output logic [board_io_pkg::hex_port_width-1:0] hex0,
    output logic [board_io_pkg::hex_port_width-1:0] hex1,
    output logic [board_io_pkg::hex_port_width-1:0] hex2,
    output logic [board_io_pkg::hex_port_width-1:0] hex3,
    output logic [board_io_pkg::hex_port_width-1:0] hex4,
    output logic [board_io_pkg::hex_port_width-1:0] hex5
);

    import board_io_pkg::*;

    // one registered pattern per digit
    seg_t [n_hex_digits-1:0] seg_q;

    // nibble to active-low pattern, gfedcba order
    function automatic seg_t hex_to_seg(input logic [hex_digit_width-1:0] nibble);
        case (nibble)
            4'h0: hex_to_seg = seg_zero;
            4'h1: hex_to_seg = 7'b111_1001;
            4'h2: hex_to_seg = 7'b010_0100;
            4'h3: hex_to_seg = 7'b011_0000;
            4'h4: hex_to_seg = 7'b001_1001;
            4'h5: hex_to_seg = 7'b001_0010;
            4'h6: hex_to_seg = 7'b000_0010;
            4'h7: hex_to_seg = 7'b111_1000;
            4'h8: hex_to_seg = 7'b000_0000;
            4'h9: hex_to_seg = 7'b001_0000;
            // lower-case b and d so they differ from 8 and 0
            4'ha: hex_to_seg = 7'b000_1000;
            4'hb: hex_to_seg = 7'b000_0011;
            4'hc: hex_to_seg = 7'b100_0110;
            4'hd: hex_to_seg = 7'b010_0001;
            4'he: hex_to_seg = 7'b000_0110;
            default: hex_to_seg = 7'b000_1110;
        endcase
    endfunction

    // digit view of the union, digit 0 in the low nibble
    always_ff @(posedge clk) begin
        for (int i = 0; i < n_hex_digits; i++) begin
            if (reset) begin
                seg_q[i] <= seg_zero;
            end else begin
                seg_q[i] <= hex_to_seg(hex_value.digit[i]);
            end
        end
    end

    // decimal points stay dark
    assign hex0 = {dp_off, seg_q[0]};
    assign hex1 = {dp_off, seg_q[1]};
    assign hex2 = {dp_off, seg_q[2]};
    assign hex3 = {dp_off, seg_q[3]};
    assign hex4 = {dp_off, seg_q[4]};
    assign hex5 = {dp_off, seg_q[5]};

endmodule

`default_nettype wire

// File: verilog/board_io_top.sv
`default_nettype none

module board_io_top (
    input  logic                                       clk,
    input  logic                                       reset,

    // board pins
    input  logic [board_io_pkg::n_board_switches-1:0]  sw,
    input  logic [board_io_pkg::n_board_keys-1:0]      key_n,
    output logic [board_io_pkg::n_red_leds-1:0]        ledr,
    output logic [board_io_pkg::n_green_leds-1:0]      ledg,
    output logic [board_io_pkg::hex_port_width-1:0]    hex0,
    output logic [board_io_pkg::hex_port_width-1:0]    hex1,
    output logic [board_io_pkg::hex_port_width-1:0]    hex2,
    output logic [board_io_pkg::hex_port_width-1:0]    hex3,
    output logic [board_io_pkg::hex_port_width-1:0]    hex4,
    output logic [board_io_pkg::hex_port_width-1:0]    hex5,

    // processor bus
    input  logic                                       bus_sel,
    input  logic                                       bus_write,
    input  logic [board_io_pkg::bus_addr_width-1:0]    bus_addr,
    input  logic [board_io_pkg::bus_data_width-1:0]    bus_wdata,
    output logic [board_io_pkg::bus_data_width-1:0]    bus_rdata
);

    import board_io_pkg::*;

    logic [n_switches-1:0] switches_raw;
    logic [n_buttons-1:0]  buttons_raw;
    logic [n_switches-1:0] switches_db;
    logic [n_buttons-1:0]  buttons_db;
    hex_word_t             hex_value;

    // keys are active low on the board, pressed reads as 1
    // unused upper bits padded with zero
    assign switches_raw = {{(n_switches - n_board_switches){1'b0}}, sw};
    assign buttons_raw  = {{(n_buttons - n_board_keys){1'b0}}, ~key_n};

    input_debouncer debouncer (
        .clk          ( clk          ),
        .reset        ( reset        ),
        .switches_raw ( switches_raw ),
        .buttons_raw  ( buttons_raw  ),
        .switches_db  ( switches_db  ),
        .buttons_db   ( buttons_db   )
    );

    // LEDs leave straight from the register file
    io_register_file registers (
        .clk          ( clk          ),
        .reset        ( reset        ),
        .bus_sel      ( bus_sel      ),
        .bus_write    ( bus_write    ),
        .bus_addr     ( bus_addr     ),
        .bus_wdata    ( bus_wdata    ),
        .bus_rdata    ( bus_rdata    ),
        .switches_db  ( switches_db  ),
        .buttons_db   ( buttons_db   ),
        .red_leds     ( ledr         ),
        .green_leds   ( ledg         ),
        .hex_value    ( hex_value    )
    );

    hex_display_driver display (
        .clk          ( clk          ),
        .reset        ( reset        ),
        .hex_value    ( hex_value    ),
        .hex0         ( hex0         ),
        .hex1         ( hex1         ),
        .hex2         ( hex2         ),
        .hex3         ( hex3         ),
        .hex4         ( hex4         ),
        .hex5         ( hex5         )
    );

endmodule

`default_nettype wire

// File: sim/board_io_chk.sv
`default_nettype none

module board_io_chk (
    input logic                                    clk,
    input logic                                    reset,
    input logic                                    bus_sel,
    input logic                                    bus_write,
    input logic [board_io_pkg::bus_addr_width-1:0] bus_addr,
    input logic [board_io_pkg::bus_data_width-1:0] bus_wdata,
    input logic [board_io_pkg::bus_data_width-1:0] bus_rdata,
    input logic [board_io_pkg::n_red_leds-1:0]     red_leds,
    input logic [board_io_pkg::n_hex_digits-1:0]   hex_points
);

    import board_io_pkg::*;

    logic read_strobe;
    logic red_write;

    assign read_strobe = bus_sel && !bus_write;
    assign red_write   = bus_sel && bus_write
                      && (bus_addr[reg_index_lsb +: reg_index_width] == reg_red_leds);

    // read data settles one cycle after the select
    rdata_known: assert property (@(posedge clk) disable iff (reset)
        read_strobe |=> !$isunknown(bus_rdata))
        else $error("bus_rdata unknown the cycle after a read");

    // LED write lands at the strobe edge
    red_leds_follow: assert property (@(posedge clk) disable iff (reset)
        red_write |=> (red_leds == $past(bus_wdata[n_red_leds-1:0])))
        else $error("red_leds differ from the written data");

    // decimal points never lit
    points_dark: assert property (@(posedge clk) (&hex_points))
        else $error("a hex decimal point is lit");

endmodule

// register file has no segment outputs
bind io_register_file board_io_chk bus_chk (
    .clk        ( clk        ),
    .reset      ( reset      ),
    .bus_sel    ( bus_sel    ),
    .bus_write  ( bus_write  ),
    .bus_addr   ( bus_addr   ),
    .bus_wdata  ( bus_wdata  ),
    .bus_rdata  ( bus_rdata  ),
    .red_leds   ( red_leds   ),
    .hex_points ( '1         )
);

// display driver sees no bus
bind hex_display_driver board_io_chk display_chk (
    .clk        ( clk                                                  ),
    .reset      ( reset                                                ),
    .bus_sel    ( 1'b0                                                 ),
    .bus_write  ( 1'b0                                                 ),
    .bus_addr   ( '0                                                   ),
    .bus_wdata  ( '0                                                   ),
    .bus_rdata  ( '0                                                   ),
    .red_leds   ( '0                                                   ),
    .hex_points ( {hex5[7], hex4[7], hex3[7], hex2[7], hex1[7], hex0[7]} )
);

`default_nettype wire

// File: sim/board_io_tb.sv
`default_nettype none

module board_io_tb;

    import board_io_pkg::*;

    // cycle budget per test, summed below
    localparam int reset_cycles       = 16;
    localparam int reset_test_cycles  = 60;
    localparam int input_test_cycles  = 200;
    localparam int led_test_cycles    = 200;
    localparam int hex_test_cycles    = 300;
    localparam int decode_test_cycles = 200;
    localparam int test_cycles        = reset_cycles + reset_test_cycles + input_test_cycles
                                      + led_test_cycles + hex_test_cycles + decode_test_cycles;
    // generous margin over the nominal run
    localparam int timeout_cycles     = 2 * test_cycles;

    logic                          clk;
    logic                          reset;
    logic [n_board_switches-1:0]   sw;
    logic [n_board_keys-1:0]       key_n;
    logic [n_red_leds-1:0]         ledr;
    logic [n_green_leds-1:0]       ledg;
    logic [hex_port_width-1:0]     hex0;
    logic [hex_port_width-1:0]     hex1;
    logic [hex_port_width-1:0]     hex2;
    logic [hex_port_width-1:0]     hex3;
    logic [hex_port_width-1:0]     hex4;
    logic [hex_port_width-1:0]     hex5;
    logic                          bus_sel;
    logic                          bus_write;
    logic [bus_addr_width-1:0]     bus_addr;
    logic [bus_data_width-1:0]     bus_wdata;
    logic [bus_data_width-1:0]     bus_rdata;

    // hex outputs indexable by digit
    logic [hex_port_width-1:0]     hex_out [n_hex_digits];

    // reference patterns, active low, gfedcba
    seg_t                          seg_table [16];

    // expected register contents
    logic [n_switches-1:0]         exp_switches;
    logic [n_buttons-1:0]          exp_buttons;
    logic [n_red_leds-1:0]         exp_red;
    logic [n_green_leds-1:0]       exp_green;
    logic [hex_word_width-1:0]     exp_hex;

    int                            errors;
    int                            checks;
    int                            cycle_count;

    board_io_top dut (
        .clk       ( clk       ),
        .reset     ( reset     ),
        .sw        ( sw        ),
        .key_n     ( key_n     ),
        .ledr      ( ledr      ),
        .ledg      ( ledg      ),
        .hex0      ( hex0      ),
        .hex1      ( hex1      ),
        .hex2      ( hex2      ),
        .hex3      ( hex3      ),
        .hex4      ( hex4      ),
        .hex5      ( hex5      ),
        .bus_sel   ( bus_sel   ),
        .bus_write ( bus_write ),
        .bus_addr  ( bus_addr  ),
        .bus_wdata ( bus_wdata ),
        .bus_rdata ( bus_rdata )
    );

    assign hex_out[0] = hex0;
    assign hex_out[1] = hex1;
    assign hex_out[2] = hex2;
    assign hex_out[3] = hex3;
    assign hex_out[4] = hex4;
    assign hex_out[5] = hex5;

    // 40 unit period
    always #20 clk = ~clk;

    // summary line, then the verdict
    task automatic finish_run();
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    endtask

    // watchdog on the whole run
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > timeout_cycles) begin
            errors = errors + 1;
            $display("run timed out after %0d cycles", timeout_cycles);
            finish_run();
        end
    end

    // byte address of a register word
    function automatic logic [bus_addr_width-1:0] word_addr(
        input logic [reg_index_width-1:0] index
    );
        word_addr = '0;
        word_addr[reg_index_lsb +: reg_index_width] = index;
    endfunction

    // register map as seen over the bus, narrow words zero-extended
    function automatic logic [bus_data_width-1:0] expected_word(
        input logic [reg_index_width-1:0] index
    );
        logic [bus_data_width-1:0] word;
        word = '0;
        if (index == reg_switches) word[n_switches-1:0] = exp_switches;
        if (index == reg_buttons) word[n_buttons-1:0] = exp_buttons;
        if (index == reg_red_leds) word[n_red_leds-1:0] = exp_red;
        if (index == reg_green_leds) word[n_green_leds-1:0] = exp_green;
        if (index == reg_hex) word[hex_word_width-1:0] = exp_hex;
        return word;
    endfunction

    task automatic check_word(input string name, input logic [bus_data_width-1:0] got,
                              input logic [bus_data_width-1:0] exp);
        checks = checks + 1;
        if (got !== exp) begin
            errors = errors + 1;
            $display("FAIL %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_leds(input string name, input logic [n_red_leds-1:0] got,
                              input logic [n_red_leds-1:0] exp);
        checks = checks + 1;
        if (got !== exp) begin
            errors = errors + 1;
            $display("FAIL %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_segments(input string name, input seg_t got, input seg_t exp);
        checks = checks + 1;
        if (got !== exp) begin
            errors = errors + 1;
            $display("FAIL %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    // segments against the table, point must stay dark
    task automatic check_digit(input int idx, input logic [hex_digit_width-1:0] nibble);
        check_segments($sformatf("hex%0d[6:0]", idx), hex_out[idx][6:0], seg_table[nibble]);
        checks = checks + 1;
        if (hex_out[idx][7] !== 1'b1) begin
            errors = errors + 1;
            $display("FAIL hex%0d[7]: got 0x%h expected 0x1", idx, hex_out[idx][7]);
        end
    endtask

    task automatic check_all_digits(input logic [hex_word_width-1:0] value);
        for (int d = 0; d < n_hex_digits; d++) begin
            check_digit(d, value[d*hex_digit_width +: hex_digit_width]);
        end
    endtask

    // called just after a falling edge, returns just after the next one
    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic bus_write_word(input logic [reg_index_width-1:0] index,
                                  input logic [bus_data_width-1:0] data);
        bus_sel   = 1'b1;
        bus_write = 1'b1;
        bus_addr  = word_addr(index);
        bus_wdata = data;
        @(negedge clk);
        bus_sel   = 1'b0;
        bus_write = 1'b0;
    endtask

    // data registered on the rising edge, sampled at the next falling one
    task automatic bus_read_word(input logic [reg_index_width-1:0] index,
                                 output logic [bus_data_width-1:0] data);
        bus_sel   = 1'b1;
        bus_write = 1'b0;
        bus_addr  = word_addr(index);
        @(negedge clk);
        bus_sel   = 1'b0;
        data      = bus_rdata;
    endtask

    task automatic read_and_check(input logic [reg_index_width-1:0] index);
        logic [bus_data_width-1:0] got;
        bus_read_word(index, got);
        check_word($sformatf("bus_rdata[index %0d]", index), got, expected_word(index));
    endtask

    task automatic test_reset_state();
        check_leds("ledr", ledr, exp_red);
        check_leds("ledg", ledg, exp_green);
        check_all_digits(exp_hex);
        for (int i = 0; i <= reg_hex; i++) begin
            read_and_check(reg_index_width'(i));
        end
    endtask

    task automatic test_debounced_inputs();
        logic [31:0]                 rnd;
        logic [n_board_switches-1:0] value;
        logic [n_board_switches-1:0] glitch;
        rnd   = $urandom;
        value = rnd[n_board_switches-1:0];
        sw    = value;
        wait_cycles(16);
        exp_switches = '0;
        exp_switches[n_board_switches-1:0] = value;
        read_and_check(reg_switches);
        // key 1 pressed, active low on the board
        key_n = 2'b01;
        wait_cycles(16);
        exp_buttons = 8'h02;
        read_and_check(reg_buttons);
        key_n = 2'b11;
        wait_cycles(16);
        exp_buttons = '0;
        read_and_check(reg_buttons);
        // short pulse, under the debounce length
        // read every cycle, the old value must never drop out
        rnd    = $urandom;
        glitch = value ^ (rnd[n_board_switches-1:0] | 1'b1);
        sw     = glitch;
        repeat (4) begin
            read_and_check(reg_switches);
        end
        sw     = value;
        repeat (16) begin
            read_and_check(reg_switches);
        end
    endtask

    task automatic test_led_registers();
        logic [31:0] rnd;
        repeat (8) begin
            rnd = $urandom;
            bus_write_word(reg_red_leds, rnd);
            exp_red = rnd[n_red_leds-1:0];
            check_leds("ledr", ledr, exp_red);
            rnd = $urandom;
            bus_write_word(reg_green_leds, rnd);
            exp_green = rnd[n_green_leds-1:0];
            check_leds("ledg", ledg, exp_green);
            read_and_check(reg_red_leds);
            read_and_check(reg_green_leds);
        end
    endtask

    task automatic test_hex_display();
        logic [31:0]               rnd;
        logic [hex_word_width-1:0] value;
        for (int p = 0; p < 7; p++) begin
            rnd = $urandom;
            value = rnd[hex_word_width-1:0];
            // first three passes walk 0..F across the digits
            if (p < 3) begin
                for (int d = 0; d < n_hex_digits; d++) begin
                    value[d*hex_digit_width +: hex_digit_width] =
                        hex_digit_width'((p * n_hex_digits + d) % 16);
                end
            end
            bus_write_word(reg_hex, {rnd[31:hex_word_width], value});
            exp_hex = value;
            // register at the write edge, segments one edge later
            wait_cycles(1);
            check_all_digits(exp_hex);
            read_and_check(reg_hex);
        end
    endtask

    task automatic test_address_decode();
        logic [31:0]               rnd;
        logic [bus_data_width-1:0] got;
        rnd = $urandom;
        bus_write_word(reg_red_leds, rnd);
        exp_red = rnd[n_red_leds-1:0];
        rnd = $urandom;
        bus_write_word(reg_green_leds, rnd);
        exp_green = rnd[n_green_leds-1:0];
        rnd = $urandom;
        bus_write_word(reg_hex, rnd);
        exp_hex = rnd[hex_word_width-1:0];
        // read-only and unmapped indexes swallow writes
        bus_write_word(reg_switches, $urandom);
        bus_write_word(reg_buttons, $urandom);
        for (int i = 5; i < 8; i++) begin
            bus_write_word(reg_index_width'(i), $urandom);
        end
        check_leds("ledr", ledr, exp_red);
        check_leds("ledg", ledg, exp_green);
        check_all_digits(exp_hex);
        for (int i = 0; i < 8; i++) begin
            read_and_check(reg_index_width'(i));
        end
        // one read per cycle, each result one cycle behind its address
        bus_sel   = 1'b1;
        bus_write = 1'b0;
        bus_addr  = word_addr(reg_index_width'(0));
        for (int i = 1; i < 8; i++) begin
            @(negedge clk);
            got      = bus_rdata;
            bus_addr = word_addr(reg_index_width'(i));
            check_word($sformatf("bus_rdata[burst %0d]", i - 1), got,
                       expected_word(reg_index_width'(i - 1)));
        end
        @(negedge clk);
        bus_sel = 1'b0;
        got     = bus_rdata;
        check_word("bus_rdata[burst 7]", got, expected_word(reg_index_width'(7)));
    endtask

    initial begin
        void'($urandom(32'ha197_92b4));
        errors      = 0;
        checks      = 0;
        cycle_count = 0;
        clk         = 1'b0;
        reset       = 1'b1;
        sw          = '0;
        // keys released
        key_n       = '1;
        bus_sel     = 1'b0;
        bus_write   = 1'b0;
        bus_addr    = '0;
        bus_wdata   = '0;

        seg_table[0]  = 7'h40;
        seg_table[1]  = 7'h79;
        seg_table[2]  = 7'h24;
        seg_table[3]  = 7'h30;
        seg_table[4]  = 7'h19;
        seg_table[5]  = 7'h12;
        seg_table[6]  = 7'h02;
        seg_table[7]  = 7'h78;
        seg_table[8]  = 7'h00;
        seg_table[9]  = 7'h10;
        seg_table[10] = 7'h08;
        // lower-case b and d
        seg_table[11] = 7'h03;
        seg_table[12] = 7'h46;
        seg_table[13] = 7'h21;
        seg_table[14] = 7'h06;
        seg_table[15] = 7'h0e;

        exp_switches = '0;
        exp_buttons  = '0;
        exp_red      = '0;
        exp_green    = '0;
        exp_hex      = '0;

        repeat (reset_cycles) @(negedge clk);
        reset = 1'b0;

        test_reset_state();
        test_debounced_inputs();
        test_led_registers();
        test_hex_display();
        test_address_decode();
        finish_run();
    end

endmodule

`default_nettype wire

// File: vlog.f
verilog/board_io_pkg.sv
verilog/input_debouncer.sv
verilog/io_register_file.sv
verilog/hex_display_driver.sv
verilog/board_io_top.sv
sim/board_io_chk.sv
sim/board_io_tb.sv

// File: Bender.yml
package:
  name: board_io

sources:
  # package first, then the blocks, top level last
  - verilog/board_io_pkg.sv
  - verilog/input_debouncer.sv
  - verilog/io_register_file.sv
  - verilog/hex_display_driver.sv
  - verilog/board_io_top.sv

  # testbench and bound assertions
  - target: simulation
    files:
      - sim/board_io_chk.sv
      - sim/board_io_tb.sv
